// ==== tart_pkg.sv ====
`default_nettype none

package tart_pkg;

   // ------------------
   // Sizing
   // ------------------
   localparam int BUS_BITS    = 8;                     // Bus data width
   localparam int ADR_BITS    = 7;                     // Bus address width
   localparam int AX_NUM      = 4;                     // Antenna count
   localparam int STORE_DEPTH = 32;                    // Sample memory words
   localparam int STORE_ABITS = $clog2(STORE_DEPTH);   // 5 for 32 words

   // ------------------
   // Address map
   // ------------------
   localparam logic [ADR_BITS-1:0] ACQ_BASE = 7'h00;   // Acquisition, 0x00..0x0F
   localparam logic [ADR_BITS-1:0] CTL_BASE = 7'h78;   // Control, 0x78..0x7F

   // Bus request from the master
   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [ADR_BITS-1:0] adr;
      logic [BUS_BITS-1:0] dat;
   } bus_req_t;

   // Slave reply, ack is a single-cycle pulse
   typedef struct packed {
      logic                ack;
      logic [BUS_BITS-1:0] dat;
   } bus_rsp_t;

   // Acquisition settings
   typedef struct packed {
      logic       enable;
      logic       debug;    // Counter source instead of antennas
      logic [2:0] delay;    // Delay-line tap
   } acq_cfg_t;

   // Capture write request into the sample store
   typedef struct packed {
      logic                   stb;
      logic [STORE_ABITS-1:0] adr;
      logic [BUS_BITS-1:0]    dat;
   } mem_wr_t;

endpackage

`default_nettype wire

// ==== bus_decoder.sv ====
`default_nettype none

module bus_decoder
   import tart_pkg::*;
(
   input  wire           b_clk,
   input  wire           reset_i,
   input  wire bus_req_t bus_i,
   output bus_rsp_t      bus_o,
   output logic          acq_stb_o,
   output logic          ctl_stb_o,
   input  wire bus_rsp_t acq_rsp_i,
   input  wire bus_rsp_t ctl_rsp_i
);

   logic acq_hit, ctl_hit, map_miss;
   logic req;                 // Live request, not yet acked
   logic acq_sel, ctl_sel;    // Held selects for the reply mux
   logic served;              // Ack already given for this stb
   logic def_ack;             // Reply for unmapped addresses

   // Region decode
   assign acq_hit  = bus_i.adr[ADR_BITS-1:4] == ACQ_BASE[ADR_BITS-1:4];
   assign ctl_hit  = bus_i.adr[ADR_BITS-1:3] == CTL_BASE[ADR_BITS-1:3];
   assign map_miss = !(acq_hit || ctl_hit);

   // Strobes drop once acked, even if the master holds stb a bit longer
   assign req       = bus_i.cyc && bus_i.stb && !served;
   assign acq_stb_o = req && acq_hit;
   assign ctl_stb_o = req && ctl_hit;

   always_ff @(posedge b_clk) begin
      if (reset_i || !bus_i.cyc) begin
         acq_sel <= 1'b0;
         ctl_sel <= 1'b0;
         served  <= 1'b0;
         def_ack <= 1'b0;
      end else begin
         acq_sel <= acq_sel ? !acq_rsp_i.ack : acq_stb_o;   // Hold until ack
         ctl_sel <= ctl_sel ? !ctl_rsp_i.ack : ctl_stb_o;
         served  <= bus_i.stb && (served || bus_o.ack);     // Clears when stb falls
         def_ack <= req && map_miss && !def_ack;            // One-cycle default reply
      end
   end

   // ------------------
   // Reply merge
   always_comb begin
      bus_o.ack = acq_rsp_i.ack || ctl_rsp_i.ack || def_ack;
      if (ctl_sel || ctl_stb_o)
         bus_o.dat = ctl_rsp_i.dat;
      else if (acq_sel || acq_stb_o)
         bus_o.dat = acq_rsp_i.dat;
      else
         bus_o.dat = '0;                                     // Unmapped reads zero
   end

endmodule

`default_nettype wire

// ==== tart_control.sv ====
`default_nettype none

module tart_control
   import tart_pkg::*;
#(
   parameter int RTIME = 4                  // Soft-reset length in cycles
) (
   input  wire                b_clk,
   input  wire                reset_i,
   input  wire bus_req_t      bus_i,
   input  wire                stb_i,
   output bus_rsp_t           rsp_o,
   input  wire acq_cfg_t      cfg_i,
   input  wire                full_i,
   input  wire [BUS_BITS-1:0] checksum_i,
   output logic               sys_rst_o
);

   localparam int CBITS = $clog2(RTIME + 1);

   logic [CBITS-1:0]    rst_cnt;            // Remaining pulse cycles
   logic                pulse;
   logic                access;             // First cycle of an access
   logic                ack_q;
   logic [BUS_BITS-1:0] dat_q, rdata;

   assign access    = stb_i && !ack_q;
   assign pulse     = rst_cnt != '0;
   assign sys_rst_o = reset_i || pulse;     // Combined reset for the peers

   // Read mux
   // Status layout is {00, full, debug, enable, delay[2:0]}
   always_comb begin
      case (bus_i.adr[2:0])
         3'd0:    rdata = {{(BUS_BITS-1){1'b0}}, pulse};
         3'd1:    rdata = {2'b00, full_i, cfg_i.debug, cfg_i.enable, cfg_i.delay};
         3'd2:    rdata = checksum_i;
         default: rdata = '0;
      endcase
   end

   always_ff @(posedge b_clk) begin
      if (reset_i) begin
         ack_q   <= 1'b0;
         rst_cnt <= '0;
      end else begin
         ack_q <= access;                   // Fixed one-cycle latency
         if (pulse)
            rst_cnt <= rst_cnt - 1'b1;      // Runs to the end, no retrigger
         else if (access && bus_i.we && bus_i.adr[2:0] == 3'd0 && bus_i.dat[0])
            rst_cnt <= CBITS'(RTIME);
      end
   end

   always_ff @(posedge b_clk) begin
      if (access && !bus_i.we)
         dat_q <= rdata;
   end

   assign rsp_o = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

// ==== tart_acquire.sv ====
`default_nettype none

module tart_acquire
   import tart_pkg::*;
(
   input  wire                   b_clk,
   input  wire                   rst_i,
   input  wire bus_req_t         bus_i,
   input  wire                   stb_i,
   output bus_rsp_t              rsp_o,
   output acq_cfg_t              cfg_o,
   input  wire [STORE_ABITS:0]   wr_count_i,
   output logic                  rd_req_o,
   output logic [STORE_ABITS-1:0] rd_adr_o,
   input  wire [BUS_BITS-1:0]    rd_data_i,
   input  wire                   rd_valid_i
);

   // ------------------
   // Register offsets
   localparam logic [3:0] REG_CFG   = 4'd0;
   localparam logic [3:0] REG_DATA  = 4'd1;    // Sample read, variable latency
   localparam logic [3:0] REG_COUNT = 4'd2;
   localparam logic [3:0] REG_CLEAR = 4'd3;    // Write clears read pointer

   acq_cfg_t               cfg_q;
   logic [STORE_ABITS-1:0] rd_ptr;
   logic                   rd_req_q;
   logic                   ack_q;
   logic [BUS_BITS-1:0]    dat_q, rdata;
   logic [3:0]             reg_sel;
   logic                   access, fetch_start, fetch_done;

   assign reg_sel     = bus_i.adr[3:0];
   assign access      = stb_i && !ack_q && !rd_req_q;        // Not while a fetch is out
   assign fetch_start = access && !bus_i.we && reg_sel == REG_DATA;
   assign fetch_done  = rd_req_q && rd_valid_i;

   always_comb begin
      case (reg_sel)
         REG_CFG:   rdata = {3'b000, cfg_q};
         REG_COUNT: rdata = {2'b00, wr_count_i};
         default:   rdata = '0;
      endcase
   end

   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         cfg_q    <= '0;
         rd_ptr   <= '0;
         rd_req_q <= 1'b0;
         ack_q    <= 1'b0;
      end else begin
         ack_q <= fetch_done || (access && !fetch_start);    // Fetch acks on rd_valid
         if (fetch_done) begin
            rd_req_q <= 1'b0;
            rd_ptr   <= rd_ptr + 1'b1;                      // Next word
         end else if (fetch_start) begin
            rd_req_q <= 1'b1;                               // Held until rd_valid
         end
         if (access && bus_i.we) begin
            if (reg_sel == REG_CFG)
               cfg_q <= bus_i.dat[$bits(acq_cfg_t)-1:0];
            if (reg_sel == REG_CLEAR)
               rd_ptr <= '0;
         end
      end
   end

   // Reply data
   always_ff @(posedge b_clk) begin
      if (fetch_done)
         dat_q <= rd_data_i;
      else if (access && !bus_i.we)
         dat_q <= rdata;
   end

   assign rsp_o    = '{ack: ack_q, dat: dat_q};
   assign cfg_o    = cfg_q;
   assign rd_req_o = rd_req_q;
   assign rd_adr_o = rd_ptr;

endmodule

`default_nettype wire

// ==== tart_capture.sv ====
`default_nettype none

module tart_capture
   import tart_pkg::*;
#(
   parameter int DEPTH = STORE_DEPTH
) (
   input  wire                 b_clk,
   input  wire                 rst_i,
   input  wire acq_cfg_t       cfg_i,
   input  wire [AX_NUM-1:0]    antenna_i,
   output mem_wr_t             wr_o,
   output logic [STORE_ABITS:0] wr_count_o,
   output logic                full_o,
   output logic [BUS_BITS-1:0] checksum_o
);

   localparam int TAPS = 8;
   localparam logic [STORE_ABITS:0] LIMIT = DEPTH[STORE_ABITS:0];

   logic [AX_NUM-1:0]      taps [TAPS];       // Antenna delay line
   logic [AX_NUM-1:0]      dbg_cnt;           // Debug sample source
   logic [AX_NUM-1:0]      sample, lo_q;      // lo_q holds first sample of a word
   logic                   en_q, start, active;
   logic                   phase;             // High on the second sample
   logic                   wr_stb;
   logic [STORE_ABITS-1:0] wr_adr;
   logic [BUS_BITS-1:0]    wr_dat;
   logic [STORE_ABITS:0]   count;
   logic [BUS_BITS-1:0]    chksum;

   assign start  = cfg_i.enable && !en_q;                   // Rising edge of enable
   assign full_o = count >= LIMIT;
   assign active = cfg_i.enable && en_q && !full_o;
   assign sample = cfg_i.debug ? dbg_cnt : taps[cfg_i.delay];

   always_ff @(posedge b_clk) begin
      taps[0] <= antenna_i;
      for (int i = 1; i < TAPS; i++)
         taps[i] <= taps[i-1];
   end

   // ------------------
   // Packing and word count
   always_ff @(posedge b_clk) begin
      if (rst_i) begin
         en_q    <= 1'b0;
         dbg_cnt <= '0;
         phase   <= 1'b0;
         wr_stb  <= 1'b0;
         count   <= '0;
         chksum  <= '0;
      end else begin
         en_q   <= cfg_i.enable;
         wr_stb <= active && phase;                         // Every second sample
         if (start) begin
            dbg_cnt <= '0;
            phase   <= 1'b0;
         end else if (active) begin
            dbg_cnt <= dbg_cnt + 1'b1;
            phase   <= !phase;
         end
         if (wr_stb) begin
            count  <= count + 1'b1;                         // Counted after the write
            chksum <= chksum + wr_dat;                      // Mod-256 sum
         end
      end
   end

   always_ff @(posedge b_clk) begin
      if (active && !phase)
         lo_q <= sample;
      if (active && phase) begin
         wr_dat <= {sample, lo_q};                          // First sample low
         wr_adr <= count[STORE_ABITS-1:0];
      end
   end

   assign wr_o       = '{stb: wr_stb, adr: wr_adr, dat: wr_dat};
   assign wr_count_o = count;
   assign checksum_o = chksum;

endmodule

`default_nettype wire

// ==== sample_store.sv ====
`default_nettype none

module sample_store
   import tart_pkg::*;
#(
   parameter int DEPTH = STORE_DEPTH
) (
   input  wire                   b_clk,
   input  wire                   reset_i,
   input  wire mem_wr_t          wr_i,
   input  wire                   rd_req_i,
   input  wire [STORE_ABITS-1:0] rd_adr_i,
   output logic [BUS_BITS-1:0]   rd_data_o,
   output logic                  rd_valid_o
);

   logic [BUS_BITS-1:0]    mem [DEPTH];   // Single-port sample RAM
   logic                   wr_gnt;
   logic                   rd_gnt;
   logic [STORE_ABITS-1:0] ram_adr;

   // ------------------
   // Fixed-priority arbiter
   // ------------------
   // Capture writer always wins
   assign wr_gnt = wr_i.stb;

   // Reader only in a free cycle, and not again while its data is out
   assign rd_gnt = rd_req_i && !wr_gnt && !rd_valid_o;

   assign ram_adr = wr_gnt ? wr_i.adr : rd_adr_i;

   // ------------------
   // RAM port
   always_ff @(posedge b_clk) begin
      if (wr_gnt)
         mem[ram_adr] <= wr_i.dat;
      else if (rd_gnt)
         rd_data_o <= mem[ram_adr];     // Registered read data
   end

   // Valid pulse one cycle after the grant
   always_ff @(posedge b_clk) begin
      if (reset_i)
         rd_valid_o <= 1'b0;
      else
         rd_valid_o <= rd_gnt;
   end

endmodule

`default_nettype wire

// ==== tart_top.sv ====
`default_nettype none

module tart_top
   import tart_pkg::*;
#(
   parameter int RTIME = 4,             // Soft-reset pulse length
   parameter int DEPTH = STORE_DEPTH    // Sample memory depth
) (
   input  wire              b_clk,
   input  wire              reset_i,
   input  wire bus_req_t    bus_i,
   output bus_rsp_t         bus_o,
   input  wire [AX_NUM-1:0] antenna_i
);

   // ------------------
   // Bus side
   logic     acq_stb, ctl_stb;
   bus_rsp_t acq_rsp, ctl_rsp;

   // Control and status
   acq_cfg_t             cfg;
   logic [STORE_ABITS:0] wr_count;
   logic                 full;
   logic [BUS_BITS-1:0]  checksum;
   logic                 sys_rst;       // reset_i OR soft reset

   // ------------------
   // Sample store ports
   mem_wr_t                wr;
   logic                   rd_req;
   logic [STORE_ABITS-1:0] rd_adr;
   logic [BUS_BITS-1:0]    rd_data;
   logic                   rd_valid;

   bus_decoder u_decoder (
      .b_clk     (b_clk),
      .reset_i   (reset_i),
      .bus_i     (bus_i),
      .bus_o     (bus_o),
      .acq_stb_o (acq_stb),
      .ctl_stb_o (ctl_stb),
      .acq_rsp_i (acq_rsp),
      .ctl_rsp_i (ctl_rsp)
   );

   tart_control #(.RTIME(RTIME)) u_control (
      .b_clk      (b_clk),
      .reset_i    (reset_i),
      .bus_i      (bus_i),
      .stb_i      (ctl_stb),
      .rsp_o      (ctl_rsp),
      .cfg_i      (cfg),
      .full_i     (full),
      .checksum_i (checksum),
      .sys_rst_o  (sys_rst)
   );

   tart_acquire u_acquire (
      .b_clk      (b_clk),
      .rst_i      (sys_rst),
      .bus_i      (bus_i),
      .stb_i      (acq_stb),
      .rsp_o      (acq_rsp),
      .cfg_o      (cfg),
      .wr_count_i (wr_count),
      .rd_req_o   (rd_req),
      .rd_adr_o   (rd_adr),
      .rd_data_i  (rd_data),
      .rd_valid_i (rd_valid)
   );

   tart_capture #(.DEPTH(DEPTH)) u_capture (
      .b_clk      (b_clk),
      .rst_i      (sys_rst),
      .cfg_i      (cfg),
      .antenna_i  (antenna_i),
      .wr_o       (wr),
      .wr_count_o (wr_count),
      .full_o     (full),
      .checksum_o (checksum)
   );

   sample_store #(.DEPTH(DEPTH)) u_store (
      .b_clk      (b_clk),
      .reset_i    (sys_rst),
      .wr_i       (wr),
      .rd_req_i   (rd_req),
      .rd_adr_i   (rd_adr),
      .rd_data_o  (rd_data),
      .rd_valid_o (rd_valid)
   );

endmodule

`default_nettype wire

// ==== tart_asserts.sv ====
`default_nettype none

module tart_asserts
   import tart_pkg::*;
(
   input wire           b_clk,
   input wire           reset_i,
   input wire bus_rsp_t bus_i,        // Merged reply to the master
   input wire mem_wr_t  wr_i,         // Capture write, stb is the grant
   input wire           rd_valid_i,
   input wire           full_i
);

   int fail_cnt = 0;                  // Failed assertion count

   // ------------------
   // Bus ack is a single-cycle pulse
   ack_pulse: assert property (@(posedge b_clk) disable iff (reset_i)
                               bus_i.ack |=> !bus_i.ack)
      else begin
         $error("bus ack stayed high for more than one cycle");
         fail_cnt++;
      end

   // Read data only comes from a write-free grant cycle
   rd_after_wr: assert property (@(posedge b_clk) disable iff (reset_i)
                                 wr_i.stb |=> !rd_valid_i)
      else begin
         $error("rd_valid followed a capture write grant");
         fail_cnt++;
      end

   // No writes once the store is full
   wr_when_full: assert property (@(posedge b_clk) disable iff (reset_i)
                                  full_i |-> !wr_i.stb)
      else begin
         $error("capture write strobe high while full");
         fail_cnt++;
      end

endmodule

bind tart_top tart_asserts u_asserts (
   .b_clk      (b_clk),
   .reset_i    (reset_i),
   .bus_i      (bus_o),
   .wr_i       (wr),
   .rd_valid_i (rd_valid),
   .full_i     (full)
);

`default_nettype wire

// ==== tart_checker.sv ====
`default_nettype none

module tart_checker
   import tart_pkg::*;
(
   input  wire                b_clk,
   input  wire                reset_i,
   input  wire bus_req_t      req_i,
   input  wire bus_rsp_t      rsp_i,
   input  wire                check_i,     // Compare this access
   input  wire [BUS_BITS-1:0] exp_i,
   output int                 pass_cnt_o,
   output int                 err_cnt_o
);

   int passes = 0;
   int errs   = 0;
   int test_no;

   // ------------------
   // Compare in the middle of the ack cycle
   always @(negedge b_clk) begin
      if (!reset_i && rsp_i.ack && check_i) begin
         test_no = passes + errs + 1;
         if (rsp_i.dat === exp_i) begin
            passes++;
            $display("Test %0d ok: read of %02h returned %02h",
                     test_no, req_i.adr, rsp_i.dat);
         end else begin
            errs++;
            $display("[ERROR] %0t: test %0d read of %02h returned %02h, expected %02h",
                     $time, test_no, req_i.adr, rsp_i.dat, exp_i);
         end
      end
   end

   assign pass_cnt_o = passes;
   assign err_cnt_o  = errs;

endmodule

`default_nettype wire

// ==== tb_tart.sv ====
`default_nettype none

module tb_tart
   import tart_pkg::*;
();

   localparam int HALF_PERIOD     = 20;    // 40-unit clock
   localparam int CYCLES_PER_LINE = 200;   // Watchdog budget per stimulus line

   // One parsed stimulus line
   typedef struct packed {
      logic [7:0]          cmd;            // ASCII command letter
      logic [ADR_BITS-1:0] adr;
      logic [7:0]          dat;            // Write data, count or idle cycles
      logic [AX_NUM-1:0]   ant;            // Antenna value for this line
      logic [7:0]          expv;
   } step_t;

   logic              b_clk;
   logic              reset_i;
   bus_req_t          bus_req;
   bus_rsp_t          bus_rsp;
   logic [AX_NUM-1:0] antenna;
   logic              check_en;            // Compare the next ack
   logic [7:0]        exp_val;
   int                passes;
   int                errors;
   int                bad_lines;
   int                seed;
   logic              loaded = 1'b0;
   step_t             steps[$];

   always #HALF_PERIOD b_clk = !b_clk;

   tart_top #(.RTIME(4), .DEPTH(STORE_DEPTH)) dut (
      .b_clk     (b_clk),
      .reset_i   (reset_i),
      .bus_i     (bus_req),
      .bus_o     (bus_rsp),
      .antenna_i (antenna)
   );

   tart_checker u_checker (
      .b_clk      (b_clk),
      .reset_i    (reset_i),
      .req_i      (bus_req),
      .rsp_i      (bus_rsp),
      .check_i    (check_en),
      .exp_i      (exp_val),
      .pass_cnt_o (passes),
      .err_cnt_o  (errors)
   );

   // Next expected word with both nibbles advanced by inc
   function automatic logic [7:0] step_word(input logic [7:0] w, input logic [3:0] inc);
      step_word = {w[7:4] + inc, w[3:0] + inc};
   endfunction

   // ------------------
   // Stimulus file
   task automatic load_steps(output logic ok);
      int         fd;
      int         n;
      int         line_no;
      string      line;
      logic [7:0] c, a, d, an, e;
      step_t      st;
      ok = 1'b0;
      line_no = 0;
      fd = $fopen("tart_stimulus.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n > 1 && line.getc(0) != "#") begin            // Skip blanks and comments
               n = $sscanf(line, "%s %h %h %h %h", c, a, d, an, e);
               if (n == 5) begin
                  st.cmd  = c;
                  st.adr  = a[ADR_BITS-1:0];
                  st.dat  = d;
                  st.ant  = an[AX_NUM-1:0];
                  st.expv = e;
                  steps.push_back(st);
               end else begin
                  $display("Stimulus line %0d is malformed and was skipped", line_no);
                  bad_lines++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // ------------------
   // Bus master that drives 5 units after a rising edge
   task automatic bus_access(input logic we, input logic [ADR_BITS-1:0] adr,
                             input logic [7:0] wdat, input logic chk,
                             input logic [7:0] want, output logic [7:0] rdat);
      int gap;
      check_en    = chk;
      exp_val     = want;
      bus_req.cyc = 1'b1;
      bus_req.stb = 1'b1;
      bus_req.we  = we;
      bus_req.adr = adr;
      bus_req.dat = wdat;
      do begin
         @(posedge b_clk);
         #5;
      end while (!bus_rsp.ack);
      rdat = bus_rsp.dat;          // Valid in the ack cycle
      @(posedge b_clk);            // Strobe still high over the edge after ack
      #5;
      bus_req.cyc = 1'b0;
      bus_req.stb = 1'b0;          // Dropped in the cycle after ack
      gap = $random(seed) & 3;
      repeat (gap + 1) begin
         @(posedge b_clk);
         #5;
      end
   endtask

   task automatic run_step(input step_t s);
      logic [7:0] rdat;
      logic [7:0] want;
      antenna = s.ant;
      case (s.cmd)
         "W": bus_access(1'b1, s.adr, s.dat, 1'b0, 8'h00, rdat);
         "R": bus_access(1'b0, s.adr, 8'h00, 1'b1, s.expv, rdat);
         "P": begin                                     // Poll until at least expv
            do begin
               bus_access(1'b0, s.adr, 8'h00, 1'b0, 8'h00, rdat);
            end while (rdat < s.expv);
         end
         "I": begin
            repeat (s.dat) begin
               @(posedge b_clk);
               #5;
            end
         end
         "K", "B": begin                                // Counter or constant burst
            want = s.expv;
            repeat (s.dat) begin
               bus_access(1'b0, s.adr, 8'h00, 1'b1, want, rdat);
               want = step_word(want, (s.cmd == "K") ? 4'd2 : 4'd0);
            end
         end
         default: begin
            $display("Unknown stimulus command %s was skipped", s.cmd);
            bad_lines++;
         end
      endcase
   endtask

   // ------------------
   // Main sequence
   initial begin : main
      logic ok;
      b_clk     = 1'b0;
      reset_i   = 1'b1;
      bus_req   = '0;
      antenna   = '0;
      check_en  = 1'b0;
      exp_val   = '0;
      seed      = 89;
      bad_lines = 0;
      load_steps(ok);
      if (!ok) begin
         $display("Could not open the stimulus file tart_stimulus.txt");
         $display("Some tests failed");
         $finish;
      end else begin
         loaded = 1'b1;
         repeat (2) @(posedge b_clk);                    // Two reset cycles
         #5;
         reset_i = 1'b0;
         foreach (steps[i])
            run_step(steps[i]);
         repeat (2) @(posedge b_clk);                    // Let the last check land
         $display("Summary: %0d checks passed, %0d failed, %0d bad lines, %0d assertion failures",
                  passes, errors, bad_lines, dut.u_asserts.fail_cnt);
         if (errors == 0 && bad_lines == 0 && passes > 0 && dut.u_asserts.fail_cnt == 0)
            $display("All tests passed");
         else
            $display("Some tests failed");
         $finish;
      end
   end

   // Watchdog scaled by stimulus length
   initial begin : watchdog
      int limit;
      wait (loaded);
      limit = steps.size() * CYCLES_PER_LINE;
      repeat (limit) @(posedge b_clk);
      $display("Timeout: the run did not finish within %0d clock cycles", limit);
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tart_stimulus.txt ====
# cmd adr dat ant exp, all hex. W write, R read and compare, P poll until >= exp,
# I idle dat cycles, K read dat words counting from exp, B read dat words equal to exp
# Register access
W 00 0D 0 00
R 00 00 0 0D
R 79 00 0 15
# Debug capture
W 00 18 0 00
P 02 00 0 08
K 01 08 0 10
# Full and checksum
P 02 00 0 20
R 02 00 0 20
R 79 00 0 38
R 00 00 0 18
W 03 00 0 00
K 01 20 0 10
R 7A 00 0 E0
# Soft reset
W 78 01 0 00
I 00 0A 0 00
R 02 00 0 00
R 00 00 0 00
R 7A 00 0 00
R 79 00 0 00
# Antenna capture, delay 2 then delay 7
I 00 0C 5 00
W 00 12 5 00
P 02 00 5 08
B 01 08 5 55
W 78 01 5 00
I 00 0C A 00
W 00 17 A 00
P 02 00 A 08
B 01 08 A AA
# Unmapped and unused addresses
R 40 00 0 00
R 7C 00 0 00
R 05 00 0 00

// ==== sources.f ====
tart_pkg.sv
bus_decoder.sv
tart_control.sv
tart_acquire.sv
tart_capture.sv
sample_store.sv
tart_top.sv
tart_asserts.sv
tart_checker.sv
tb_tart.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_tart -o tb_tart
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_tart +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "All tests passed" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
